//--- source/vmaPkg.sv
package vmaPkg;

  localparam int sectionBits = 5;
  localparam int wordBits = 18;
  localparam int addrBits = sectionBits + wordBits;
  localparam int magicBits = 5;
  localparam int trapMixBits = 4;
  localparam int diagSelBits = 3;
  localparam int ebusBits = 24;

  // AC addresses occupy words 0 to 15
  localparam int acBits = 4;

  typedef logic [sectionBits-1:0] sectionT;
  typedef logic [wordBits-1:0] wordT;

  // Section in the high bits, in-section word in the low bits
  typedef logic [addrBits-1:0] vmaAddrT;

  typedef logic [magicBits-1:0] magicT;
  typedef logic [trapMixBits-1:0] trapMixT;
  typedef logic [diagSelBits-1:0] diagSelT;
  typedef logic [ebusBits-1:0] ebusWordT;

  // Source of the VMA section bits on a load
  typedef enum logic [1:0] {
    keepSec,
    pcSec,
    prevSec,
    adSec
  } vmaxSelT;

  typedef struct packed {
    logic loadVma;
    logic incVma;
    logic adSel;
    logic vmaxEn;
    vmaxSelT vmaxSel;
    logic magicMode;
    logic loadPc;
    logic loadHeld;
    logic selHeld;
    logic datao;
    logic loadPrevCtx;
  } vmaCtlT;

  typedef struct packed {
    logic readOrWrite;
    logic fetch;
    logic extended;
    logic uebrRef;
    logic adrErr;
  } memRefT;

  typedef struct packed {
    logic acRef;
    logic localAc;
    logic match;
    logic vmaSec0;
    logic pcSec0;
    logic prevSec0;
  } vmaFlagsT;

endpackage

//--- source/vmaAdder.sv
`timescale 1ns/1ns

module vmaAdder (
  input  logic              magicMode,
  input  logic              inc,
  input  vmaPkg::vmaAddrT   pc,
  input  vmaPkg::magicT     magic,
  input  vmaPkg::trapMixT   trapMix,
  output vmaPkg::wordT      nextWord
);

  vmaPkg::wordT pcWord;
  vmaPkg::wordT magicExt;
  vmaPkg::wordT trapExt;
  vmaPkg::wordT incExt;

  assign pcWord = pc[vmaPkg::wordBits-1:0];
  assign magicExt = vmaPkg::wordT'(magic);
  assign trapExt = vmaPkg::wordT'(trapMix);
  assign incExt = vmaPkg::wordT'(inc);

  // Both sums wrap within the section
  always_comb begin
    if (magicMode) begin
      nextWord = pcWord + magicExt;
    end else begin
      // Trap mix offset, with the increment as carry in
      nextWord = pcWord + trapExt + incExt;
    end
  end

endmodule

//--- source/vmaReg.sv
`timescale 1ns/1ns

module vmaReg (
  input  logic              clk,
  input  logic              rstN,
  input  vmaPkg::vmaCtlT    ctl,
  input  vmaPkg::vmaAddrT   edpAd,
  input  vmaPkg::wordT      nextWord,
  input  vmaPkg::vmaAddrT   pc,
  input  vmaPkg::sectionT   prevSection,
  output vmaPkg::vmaAddrT   vma
);

  vmaPkg::sectionT curSec;
  vmaPkg::sectionT loadSec;
  vmaPkg::wordT loadWord;

  assign curSec = vma[vmaPkg::addrBits-1:vmaPkg::wordBits];

  // Word comes from the AD bus or from the address adder
  assign loadWord = ctl.adSel ? edpAd[vmaPkg::wordBits-1:0] : nextWord;

  // Four-way section select, held when VMAX is disabled
  always_comb begin
    loadSec = curSec;
    if (ctl.vmaxEn) begin
      case (ctl.vmaxSel)
        vmaPkg::keepSec: loadSec = curSec;
        vmaPkg::pcSec:   loadSec = pc[vmaPkg::addrBits-1:vmaPkg::wordBits];
        vmaPkg::prevSec: loadSec = prevSection;
        vmaPkg::adSec:   loadSec = edpAd[vmaPkg::addrBits-1:vmaPkg::wordBits];
        default:         loadSec = curSec;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      vma <= '0;
    end else if (ctl.loadVma) begin
      vma <= {loadSec, loadWord};
    end else if (ctl.incVma) begin
      // Counts across the section boundary and wraps at the top
      vma <= vma + vmaPkg::vmaAddrT'(1);
    end
  end

endmodule

//--- source/vmaContext.sv
`timescale 1ns/1ns

module vmaContext (
  input  logic              clk,
  input  logic              rstN,
  input  vmaPkg::vmaCtlT    ctl,
  input  vmaPkg::vmaAddrT   vma,
  input  vmaPkg::vmaAddrT   edpAd,
  output vmaPkg::vmaAddrT   pc,
  output vmaPkg::vmaAddrT   held,
  output vmaPkg::vmaAddrT   adrBrk,
  output vmaPkg::vmaAddrT   heldOrPc,
  output vmaPkg::sectionT   prevSection
);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pc <= '0;
      held <= '0;
    end else begin
      if (ctl.loadPc) begin
        pc <= vma;
      end
      // Snapshot of the VMA for later restore
      if (ctl.loadHeld) begin
        held <= vma;
      end
    end
  end

  // Address break and previous context come from DATAO and the AD bus
  always_ff @(posedge clk) begin
    if (!rstN) begin
      adrBrk <= '0;
      prevSection <= '0;
    end else begin
      if (ctl.datao) begin
        adrBrk <= edpAd;
      end
      if (ctl.loadPrevCtx) begin
        prevSection <= edpAd[vmaPkg::addrBits-1:vmaPkg::wordBits];
      end
    end
  end

  assign heldOrPc = ctl.selHeld ? held : pc;

endmodule

//--- source/vmaDecode.sv
`timescale 1ns/1ns

module vmaDecode (
  input  vmaPkg::memRefT    memRef,
  input  vmaPkg::vmaAddrT   vma,
  input  vmaPkg::vmaAddrT   pc,
  input  vmaPkg::vmaAddrT   adrBrk,
  input  vmaPkg::sectionT   prevSection,
  output vmaPkg::vmaFlagsT  flags
);

  vmaPkg::sectionT vmaSec;
  vmaPkg::sectionT pcSec;
  logic vmaSec01;
  logic isLocal;
  logic acWord;

  assign vmaSec = vma[vmaPkg::addrBits-1:vmaPkg::wordBits];
  assign pcSec = pc[vmaPkg::addrBits-1:vmaPkg::wordBits];

  // Sections 0 and 1 share the low bit only
  assign vmaSec01 = vmaSec[vmaPkg::sectionBits-1:1] == '0;
  assign isLocal = ~memRef.extended | memRef.fetch | vmaSec01;

  // Word falls in the AC block
  assign acWord = vma[vmaPkg::wordBits-1:vmaPkg::acBits] == '0;

  assign flags.acRef = acWord & isLocal & memRef.readOrWrite &
                       ~memRef.uebrRef & ~memRef.adrErr;
  assign flags.localAc = isLocal & ~vmaSec01 & acWord & ~memRef.adrErr;
  assign flags.match = vma == adrBrk;
  assign flags.vmaSec0 = vmaSec == '0;
  assign flags.pcSec0 = pcSec == '0;
  assign flags.prevSec0 = prevSection == '0;

endmodule

//--- source/vmaDiag.sv
`timescale 1ns/1ns

module vmaDiag (
  input  logic              readVma,
  input  vmaPkg::diagSelT   diagSel,
  input  vmaPkg::vmaAddrT   vma,
  input  vmaPkg::vmaAddrT   pc,
  input  vmaPkg::vmaAddrT   held,
  input  vmaPkg::vmaAddrT   adrBrk,
  input  vmaPkg::sectionT   prevSection,
  input  vmaPkg::vmaFlagsT  flags,
  output vmaPkg::ebusWordT  ebusData,
  output logic              ebusDriving
);

  vmaPkg::ebusWordT view;

  // Each view zero-extended to the bus width
  always_comb begin
    case (diagSel)
      3'd0:    view = vmaPkg::ebusWordT'(vma);
      3'd1:    view = vmaPkg::ebusWordT'(pc);
      3'd2:    view = vmaPkg::ebusWordT'(held);
      3'd3:    view = vmaPkg::ebusWordT'(adrBrk);
      3'd4:    view = vmaPkg::ebusWordT'(prevSection);
      3'd5:    view = vmaPkg::ebusWordT'(flags);
      default: view = '0;
    endcase
  end

  // Bus stays quiet unless the diagnostic read is active
  assign ebusData = readVma ? view : '0;
  assign ebusDriving = readVma;

endmodule

//--- source/vmaTop.sv
`timescale 1ns/1ns

module vmaTop (
  input  logic              clk,
  input  logic              rstN,
  input  vmaPkg::vmaCtlT    ctl,
  input  vmaPkg::memRefT    memRef,
  input  vmaPkg::vmaAddrT   edpAd,
  input  vmaPkg::magicT     magic,
  input  vmaPkg::trapMixT   trapMix,
  input  vmaPkg::diagSelT   diagSel,
  input  logic              readVma,
  output vmaPkg::vmaAddrT   vma,
  output vmaPkg::vmaAddrT   pc,
  output vmaPkg::vmaAddrT   heldOrPc,
  output vmaPkg::vmaFlagsT  flags,
  output vmaPkg::ebusWordT  ebusData,
  output logic              ebusDriving
);

  vmaPkg::wordT nextWord;
  vmaPkg::vmaAddrT held;
  vmaPkg::vmaAddrT adrBrk;
  vmaPkg::sectionT prevSection;

  vmaAdder adder0 (
    .magicMode(ctl.magicMode),
    .inc(ctl.incVma),
    .pc(pc),
    .magic(magic),
    .trapMix(trapMix),
    .nextWord(nextWord)
  );

  vmaReg reg0 (
    .clk(clk),
    .rstN(rstN),
    .ctl(ctl),
    .edpAd(edpAd),
    .nextWord(nextWord),
    .pc(pc),
    .prevSection(prevSection),
    .vma(vma)
  );

  vmaContext context0 (
    .clk(clk),
    .rstN(rstN),
    .ctl(ctl),
    .vma(vma),
    .edpAd(edpAd),
    .pc(pc),
    .held(held),
    .adrBrk(adrBrk),
    .heldOrPc(heldOrPc),
    .prevSection(prevSection)
  );

  vmaDecode decode0 (
    .memRef(memRef),
    .vma(vma),
    .pc(pc),
    .adrBrk(adrBrk),
    .prevSection(prevSection),
    .flags(flags)
  );

  vmaDiag diag0 (
    .readVma(readVma),
    .diagSel(diagSel),
    .vma(vma),
    .pc(pc),
    .held(held),
    .adrBrk(adrBrk),
    .prevSection(prevSection),
    .flags(flags),
    .ebusData(ebusData),
    .ebusDriving(ebusDriving)
  );

endmodule

//--- sim/vma_assert.sv
`timescale 1ns/1ns

module vmaAssert (
  input  logic              clk,
  input  logic              rstN,
  input  vmaPkg::vmaCtlT    ctl,
  input  vmaPkg::vmaAddrT   vma,
  input  vmaPkg::vmaAddrT   pc,
  input  vmaPkg::vmaAddrT   held,
  input  vmaPkg::vmaAddrT   adrBrk,
  input  vmaPkg::sectionT   prevSection
);

  resetClears: assert property (@(posedge clk)
    !rstN |=> (vma == '0 && pc == '0 && held == '0 && adrBrk == '0 && prevSection == '0))
    else $error("registers not cleared one cycle after reset");

  pcHolds: assert property (@(posedge clk) disable iff (!rstN)
    !ctl.loadPc |=> $stable(pc))
    else $error("pc changed without loadPc");

  heldHolds: assert property (@(posedge clk) disable iff (!rstN)
    !ctl.loadHeld |=> $stable(held))
    else $error("held changed without loadHeld");

endmodule

bind vmaTop vmaAssert assert0 (
  .clk(clk),
  .rstN(rstN),
  .ctl(ctl),
  .vma(vma),
  .pc(pc),
  .held(held),
  .adrBrk(adrBrk),
  .prevSection(prevSection)
);

//--- sim/vmaCheck.sv
`timescale 1ns/1ns

module vmaCheck (
  input  logic              clk,
  input  logic              rstN,
  input  vmaPkg::vmaCtlT    ctl,
  input  vmaPkg::memRefT    memRef,
  input  vmaPkg::vmaAddrT   edpAd,
  input  vmaPkg::magicT     magic,
  input  vmaPkg::trapMixT   trapMix,
  input  vmaPkg::diagSelT   diagSel,
  input  logic              readVma,
  input  vmaPkg::vmaAddrT   vma,
  input  vmaPkg::vmaAddrT   pc,
  input  vmaPkg::vmaAddrT   heldOrPc,
  input  vmaPkg::vmaFlagsT  flags,
  input  vmaPkg::ebusWordT  ebusData,
  input  logic              ebusDriving,
  output int                errorCount
);

  // Model registers
  vmaPkg::vmaAddrT mVma;
  vmaPkg::vmaAddrT mPc;
  vmaPkg::vmaAddrT mHeld;
  vmaPkg::vmaAddrT mBrk;
  vmaPkg::sectionT mPrev;
  logic started;

  initial begin
    errorCount = 0;
    started = 1'b0;
  end

  function automatic vmaPkg::vmaFlagsT modelFlags();
    vmaPkg::vmaFlagsT f;
    logic [4:0] sec;
    logic nearRef;
    logic acWord;
    sec = mVma[22:18];
    nearRef = !memRef.extended || memRef.fetch || (sec <= 5'd1);
    acWord = (mVma[17:4] == 14'h0000);
    f.acRef = acWord && nearRef && memRef.readOrWrite && !memRef.uebrRef && !memRef.adrErr;
    f.localAc = nearRef && (sec >= 5'd2) && acWord && !memRef.adrErr;
    f.match = (mVma == mBrk);
    f.vmaSec0 = (sec == 5'd0);
    f.pcSec0 = (mPc[22:18] == 5'd0);
    f.prevSec0 = (mPrev == 5'd0);
    return f;
  endfunction

  function automatic vmaPkg::ebusWordT modelBus();
    vmaPkg::ebusWordT v;
    case (diagSel)
      3'd0: v = {1'b0, mVma};
      3'd1: v = {1'b0, mPc};
      3'd2: v = {1'b0, mHeld};
      3'd3: v = {1'b0, mBrk};
      3'd4: v = {19'h00000, mPrev};
      3'd5: v = {18'h00000, modelFlags()};
      default: v = 24'h000000;
    endcase
    return readVma ? v : 24'h000000;
  endfunction

  task automatic checkValue(input string name, input logic [23:0] expVal,
                            input logic [23:0] actVal);
    if (actVal !== expVal) begin
      $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, expVal, actVal);
      errorCount++;
    end
  endtask

  always @(posedge clk) begin
    logic [17:0] wordNext;
    logic [4:0] secNext;
    vmaPkg::vmaAddrT vmaNext;
    // Outputs still show the state left by the previous edge
    if (started) begin
      checkValue("vma", {1'b0, mVma}, {1'b0, vma});
      checkValue("pc", {1'b0, mPc}, {1'b0, pc});
      checkValue("heldOrPc", {1'b0, ctl.selHeld ? mHeld : mPc}, {1'b0, heldOrPc});
      checkValue("flags", {18'h00000, modelFlags()}, {18'h00000, flags});
      checkValue("ebusData", modelBus(), ebusData);
      checkValue("ebusDriving", {23'h000000, readVma}, {23'h000000, ebusDriving});
    end
    if (!rstN) begin
      mVma = '0;
      mPc = '0;
      mHeld = '0;
      mBrk = '0;
      mPrev = '0;
      started = 1'b1;
    end else begin
      if (ctl.magicMode) begin
        wordNext = mPc[17:0] + {13'h0000, magic};
      end else begin
        wordNext = mPc[17:0] + {14'h0000, trapMix} + {17'h00000, ctl.incVma};
      end
      if (ctl.adSel) begin
        wordNext = edpAd[17:0];
      end
      secNext = mVma[22:18];
      if (ctl.vmaxEn) begin
        case (ctl.vmaxSel)
          vmaPkg::pcSec: secNext = mPc[22:18];
          vmaPkg::prevSec: secNext = mPrev;
          vmaPkg::adSec: secNext = edpAd[22:18];
          default: secNext = mVma[22:18];
        endcase
      end
      vmaNext = mVma;
      if (ctl.loadVma) begin
        vmaNext = {secNext, wordNext};
      end else if (ctl.incVma) begin
        vmaNext = mVma + 23'd1;
      end
      if (ctl.loadPc) mPc = mVma;
      if (ctl.loadHeld) mHeld = mVma;
      if (ctl.datao) mBrk = edpAd;
      if (ctl.loadPrevCtx) mPrev = edpAd[22:18];
      mVma = vmaNext;
    end
  end

endmodule

//--- sim/vmaTb.sv
`timescale 1ns/1ns

module vmaTb;

  localparam int resetCycles = 8;
  localparam int testCycles = 3000;
  localparam int periodNs = 40;
  localparam int watchdogNs = (testCycles + resetCycles + 20) * periodNs;

  logic clk;
  logic rstN;
  vmaPkg::vmaCtlT ctl;
  vmaPkg::memRefT memRef;
  vmaPkg::vmaAddrT edpAd;
  vmaPkg::magicT magic;
  vmaPkg::trapMixT trapMix;
  vmaPkg::diagSelT diagSel;
  logic readVma;

  vmaPkg::vmaAddrT vma;
  vmaPkg::vmaAddrT pc;
  vmaPkg::vmaAddrT heldOrPc;
  vmaPkg::vmaFlagsT flags;
  vmaPkg::ebusWordT ebusData;
  logic ebusDriving;
  int errorCount;

  vmaTop dut0 (
    .clk(clk),
    .rstN(rstN),
    .ctl(ctl),
    .memRef(memRef),
    .edpAd(edpAd),
    .magic(magic),
    .trapMix(trapMix),
    .diagSel(diagSel),
    .readVma(readVma),
    .vma(vma),
    .pc(pc),
    .heldOrPc(heldOrPc),
    .flags(flags),
    .ebusData(ebusData),
    .ebusDriving(ebusDriving)
  );

  vmaCheck check0 (
    .clk(clk),
    .rstN(rstN),
    .ctl(ctl),
    .memRef(memRef),
    .edpAd(edpAd),
    .magic(magic),
    .trapMix(trapMix),
    .diagSel(diagSel),
    .readVma(readVma),
    .vma(vma),
    .pc(pc),
    .heldOrPc(heldOrPc),
    .flags(flags),
    .ebusData(ebusData),
    .ebusDriving(ebusDriving),
    .errorCount(errorCount)
  );

  always #(periodNs / 2) clk = ~clk;

  // Small addresses give AC words and break matches, high ones exercise the count wrap
  task automatic driveRandom();
    logic [31:0] r;
    logic [1:0] mode;
    r = $urandom;
    ctl = r[$bits(vmaPkg::vmaCtlT)-1:0];
    r = $urandom;
    memRef = r[4:0];
    magic = r[9:5];
    trapMix = r[13:10];
    diagSel = r[16:14];
    readVma = r[17];
    mode = r[19:18];
    r = $urandom;
    case (mode)
      2'd0: edpAd = {3'b000, r[1:0], 13'h0000, r[6:2]};
      2'd1: edpAd = {5'h1f, 16'hffff, r[1:0]};
      default: edpAd = r[22:0];
    endcase
  endtask

  initial begin
    void'($urandom(32'hdbd8837e));
    clk = 1'b0;
    rstN = 1'b0;
    ctl = '0;
    memRef = '0;
    edpAd = '0;
    magic = '0;
    trapMix = '0;
    diagSel = '0;
    readVma = 1'b0;
    repeat (resetCycles) @(negedge clk);
    rstN = 1'b1;
    repeat (testCycles) begin
      @(negedge clk);
      driveRandom();
    end
    // Let the last stimulus reach the checker
    repeat (2) @(negedge clk);
    $display("Closing: %0d errors over %0d cycles", errorCount, testCycles);
    if (errorCount == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    #(watchdogNs);
    $display("Timeout: the run did not finish within %0d ns", watchdogNs);
    $display("TEST FAIL");
    $finish;
  end

endmodule

//--- sim.f
source/vmaPkg.sv
source/vmaAdder.sv
source/vmaReg.sv
source/vmaContext.sv
source/vmaDecode.sv
source/vmaDiag.sv
source/vmaTop.sv
sim/vma_assert.sv
sim/vmaCheck.sv
sim/vmaTb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = vmaTb
FILELIST = sim.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
